//--- hdl/stcPkg.sv
package stcPkg;

    localparam int SAMPLE_W        = 12;
    localparam int SYMBOL_W        = 12;
    localparam int NDX_W           = 4;
    localparam int BUF_AW          = 8;
    localparam int BUF_DEPTH       = 2 ** BUF_AW;
    localparam int PILOT_LEN       = 32;   // pilot samples skipped after sof
    localparam int INIT_COUNT      = 16;   // idle cycles from trellis start to first read
    localparam int CLKS_PER_OUTPUT = 2;    // decimation, cycles per read
    localparam int TAP_GUARD       = 8;    // margin so that both taps are already written

    // saturation limits of the combiner
    localparam int SYM_MAX         = 2 ** (SYMBOL_W - 1) - 1;
    localparam int SYM_MIN         = -(2 ** (SYMBOL_W - 1));

    typedef logic signed [SAMPLE_W-1:0]   sampleT;
    typedef logic signed [SYMBOL_W-1:0]   symbolT;
    typedef logic signed [NDX_W-1:0]      tapNdxT;
    typedef logic        [BUF_AW-1:0]     bufAddrT;
    typedef logic        [BUF_AW:0]       bufPtrT;    // address plus a wrap bit
    typedef logic signed [BUF_AW:0]       bufFillT;   // write minus read pointer
    typedef logic        [2*SAMPLE_W-1:0] iqWordT;    // {re, im} as stored in the buffer

    typedef enum logic {
        waitValid,
        waitDecimation
    } readStateT;

    typedef enum logic [1:0] {
        idle,
        waitAck,
        waitRelease
    } portStateT;

endpackage

//--- hdl/stcInterfaces.sv
`timescale 1ns/1ps

// one buffer write per accepted sample
interface sampleIf;
    logic           wrEn;
    logic           sof;
    stcPkg::sampleT re;
    stcPkg::sampleT im;
    logic           full;

    modport capture (output wrEn, sof, re, im, input full);
    modport align   (input wrEn, sof, re, im, output full);
endinterface

// both taps of one symbol, valid/ready
interface tapPairIf;
    logic           valid;
    logic           ready;
    stcPkg::sampleT re0;
    stcPkg::sampleT im0;
    stcPkg::sampleT re1;
    stcPkg::sampleT im1;
    logic           lastOfFour;   // fourth read of a group

    modport source (
        output valid, re0, im0, re1, im1, lastOfFour,
        input  ready
    );
    modport sink (
        input  valid, re0, im0, re1, im1, lastOfFour,
        output ready
    );
endinterface

// combiner result, valid/ready
interface symbolIf;
    logic           valid;
    logic           ready;
    stcPkg::symbolT sumRe;
    stcPkg::symbolT sumIm;
    stcPkg::symbolT difRe;
    stcPkg::symbolT difIm;
    logic           interpolate;

    modport source (
        output valid, sumRe, sumIm, difRe, difIm, interpolate,
        input  ready
    );
    modport sink (
        input  valid, sumRe, sumIm, difRe, difIm, interpolate,
        output ready
    );
endinterface

//--- hdl/stcSampleCapture.sv
`timescale 1ns/1ps

module stcSampleCapture (
    input  logic           clk,
    input  logic           reset,
    input  logic           inReq,
    input  logic           inSof,
    input  stcPkg::sampleT inRe,
    input  stcPkg::sampleT inIm,
    output logic           inAck,
    sampleIf.capture       smp
);

    stcPkg::portStateT state;
    logic              accept;

    // a pending request is taken as soon as the buffer has room
    assign accept = inReq && !smp.full &&
                    (state == stcPkg::idle || state == stcPkg::waitAck);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stcPkg::idle;
            inAck    <= 1'b0;
            smp.wrEn <= 1'b0;
        end else begin
            smp.wrEn <= accept;   // single cycle write strobe
            case (state)
                stcPkg::idle, stcPkg::waitAck: begin
                    if (accept) begin
                        inAck <= 1'b1;
                        state <= stcPkg::waitRelease;
                    end else if (inReq) begin
                        state <= stcPkg::waitAck;   // held off by full
                    end
                end
                stcPkg::waitRelease: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= stcPkg::idle;
                    end
                end
                default: state <= stcPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            smp.sof <= inSof;
            smp.re  <= inRe;
            smp.im  <= inIm;
        end
    end

endmodule

//--- hdl/stcTwoReadRam.sv
`timescale 1ns/1ps

module stcTwoReadRam (
    input  logic            clk,
    input  logic            wrEn,
    input  stcPkg::bufAddrT wrAddr,
    input  stcPkg::iqWordT  wrData,
    input  stcPkg::bufAddrT rdAddrA,
    input  stcPkg::bufAddrT rdAddrB,
    input  logic            rdEn,
    output stcPkg::iqWordT  rdDataA,
    output stcPkg::iqWordT  rdDataB
);

    // addresses wrap naturally at the buffer depth
    stcPkg::iqWordT mem [stcPkg::BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // both read ports hold their last word while rdEn is low
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdDataA <= mem[rdAddrA];
            rdDataB <= mem[rdAddrB];
        end
    end

endmodule

//--- hdl/stcFrameAlign.sv
`timescale 1ns/1ps

module stcFrameAlign (
    input  logic           clk,
    input  logic           reset,
    input  logic           estimatesDone,
    input  logic           lastSample,
    input  stcPkg::tapNdxT ndx0,
    input  stcPkg::tapNdxT ndx1,
    output logic           trellisStart,
    sampleIf.align         smp,
    tapPairIf.source       taps
);

    stcPkg::bufPtrT    wrPtr;
    stcPkg::bufPtrT    rdPtr;
    stcPkg::bufPtrT    sofPtr;     // first sample after the pilot block
    stcPkg::bufFillT   fill;
    stcPkg::bufAddrT   rdAddrA;
    stcPkg::bufAddrT   rdAddrB;
    stcPkg::iqWordT    rdDataA;
    stcPkg::iqWordT    rdDataB;
    stcPkg::readStateT rdState;
    logic              estimatesReady;
    logic              sofSeen;
    logic              frameActive;
    logic              readNow;
    logic [1:0]        readCnt;
    logic [$clog2(stcPkg::INIT_COUNT)-1:0]      initCnt;
    logic [$clog2(stcPkg::CLKS_PER_OUTPUT)-1:0] decCnt;

    // signed, since the read pointer may jump ahead of the writes
    assign fill     = wrPtr - rdPtr;
    assign smp.full = (fill >= stcPkg::BUF_DEPTH - stcPkg::TAP_GUARD);

    assign rdAddrA = rdPtr[stcPkg::BUF_AW-1:0] + stcPkg::bufAddrT'(ndx0);
    assign rdAddrB = rdPtr[stcPkg::BUF_AW-1:0] + stcPkg::bufAddrT'(ndx1);

    assign readNow = frameActive && (initCnt == '0) && (rdState == stcPkg::waitValid) &&
                     (fill >= stcPkg::TAP_GUARD) && taps.ready && !lastSample;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (smp.wrEn) wrPtr <= wrPtr + 1'b1;
            if (trellisStart) begin
                rdPtr <= sofPtr;   // skip the pilot
            end else if (readNow) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estimatesReady <= 1'b0;
            sofSeen        <= 1'b0;
            trellisStart   <= 1'b0;
        end else begin
            if (estimatesDone) begin
                estimatesReady <= 1'b1;
            end else if (trellisStart) begin
                estimatesReady <= 1'b0;
            end
            if (smp.wrEn && smp.sof) begin
                sofSeen <= 1'b1;
            end else if (trellisStart) begin
                sofSeen <= 1'b0;
            end
            // own output fed back so the pulse lasts one cycle
            trellisStart <= estimatesReady && sofSeen && !frameActive && !trellisStart;
        end
    end

    always_ff @(posedge clk) begin
        if (smp.wrEn && smp.sof) sofPtr <= wrPtr + stcPkg::bufPtrT'(stcPkg::PILOT_LEN);
        if (readNow) taps.lastOfFour <= (readCnt == 2'd3);
    end

    always_ff @(posedge clk) begin
        if (reset || lastSample) begin
            frameActive <= 1'b0;
            initCnt     <= '0;
            rdState     <= stcPkg::waitValid;
            decCnt      <= '0;
            readCnt     <= '0;
        end else begin
            if (trellisStart) begin
                frameActive <= 1'b1;
                initCnt     <= ($bits(initCnt))'(stcPkg::INIT_COUNT - 1);
                readCnt     <= '0;
            end else if (initCnt != '0) begin
                initCnt <= initCnt - 1'b1;
            end
            case (rdState)
                stcPkg::waitValid: begin
                    if (readNow) begin
                        readCnt <= readCnt + 1'b1;
                        decCnt  <= ($bits(decCnt))'(stcPkg::CLKS_PER_OUTPUT - 2);
                        rdState <= stcPkg::waitDecimation;
                    end
                end
                stcPkg::waitDecimation: begin
                    if (decCnt == '0) rdState <= stcPkg::waitValid;
                    else decCnt <= decCnt - 1'b1;
                end
                default: rdState <= stcPkg::waitValid;
            endcase
        end
    end

    // valid lasts until the combiner takes the pair
    always_ff @(posedge clk) begin
        if (reset) begin
            taps.valid <= 1'b0;
        end else if (readNow) begin
            taps.valid <= 1'b1;
        end else if (taps.ready) begin
            taps.valid <= 1'b0;
        end
    end

    assign taps.re0 = rdDataA[2*stcPkg::SAMPLE_W-1:stcPkg::SAMPLE_W];
    assign taps.im0 = rdDataA[stcPkg::SAMPLE_W-1:0];
    assign taps.re1 = rdDataB[2*stcPkg::SAMPLE_W-1:stcPkg::SAMPLE_W];
    assign taps.im1 = rdDataB[stcPkg::SAMPLE_W-1:0];

    stcTwoReadRam u_ram (
        .clk     (clk),
        .wrEn    (smp.wrEn),
        .wrAddr  (wrPtr[stcPkg::BUF_AW-1:0]),
        .wrData  ({smp.re, smp.im}),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdEn    (readNow),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

endmodule

//--- hdl/stcBranchCombiner.sv
`timescale 1ns/1ps

module stcBranchCombiner (
    input  logic   clk,
    input  logic   reset,
    tapPairIf.sink taps,
    symbolIf.source sym
);

    logic take;

    // clamp a one bit wider result to the symbol range
    function automatic stcPkg::symbolT sat(input logic signed [stcPkg::SAMPLE_W:0] x);
        if (x > stcPkg::SYM_MAX) begin
            return stcPkg::symbolT'(stcPkg::SYM_MAX);
        end else if (x < stcPkg::SYM_MIN) begin
            return stcPkg::symbolT'(stcPkg::SYM_MIN);
        end
        return stcPkg::symbolT'(x);
    endfunction

    function automatic stcPkg::symbolT satAdd(input stcPkg::sampleT a, input stcPkg::sampleT b,
                                              input logic subtract);
        logic signed [stcPkg::SAMPLE_W:0] wa;
        logic signed [stcPkg::SAMPLE_W:0] wb;
        wa = a;   // sign extended
        wb = b;
        return subtract ? sat(wa - wb) : sat(wa + wb);
    endfunction

    assign taps.ready = !sym.valid || sym.ready;   // empty or draining this cycle
    assign take       = taps.valid && taps.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            sym.valid <= 1'b0;
        end else if (take) begin
            sym.valid <= 1'b1;
        end else if (sym.ready) begin
            sym.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            sym.sumRe       <= satAdd(taps.re0, taps.re1, 1'b0);
            sym.sumIm       <= satAdd(taps.im0, taps.im1, 1'b0);
            sym.difRe       <= satAdd(taps.re0, taps.re1, 1'b1);
            sym.difIm       <= satAdd(taps.im0, taps.im1, 1'b1);
            sym.interpolate <= taps.lastOfFour;
        end
    end

endmodule

//--- hdl/stcOutputPort.sv
`timescale 1ns/1ps

module stcOutputPort (
    input  logic           clk,
    input  logic           reset,
    symbolIf.sink          sym,
    output logic           outReq,
    input  logic           outAck,
    output stcPkg::symbolT outSumRe,
    output stcPkg::symbolT outSumIm,
    output stcPkg::symbolT outDifRe,
    output stcPkg::symbolT outDifIm,
    output logic           outInterpolate
);

    stcPkg::portStateT state;
    logic              holdFull;
    logic              load;

    assign sym.ready = (state == stcPkg::idle) && !holdFull;
    assign load      = sym.valid && sym.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stcPkg::idle;
            holdFull <= 1'b0;
            outReq   <= 1'b0;
        end else begin
            case (state)
                stcPkg::idle: begin
                    if (load) begin
                        holdFull <= 1'b1;
                    end else if (holdFull) begin
                        outReq <= 1'b1;   // one cycle after the hold register fills
                        state  <= stcPkg::waitAck;
                    end
                end
                stcPkg::waitAck: begin
                    if (outAck) begin
                        outReq <= 1'b0;
                        state  <= stcPkg::waitRelease;
                    end
                end
                stcPkg::waitRelease: begin
                    if (!outAck) begin
                        holdFull <= 1'b0;   // exchange complete
                        state    <= stcPkg::idle;
                    end
                end
                default: state <= stcPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outSumRe       <= sym.sumRe;
            outSumIm       <= sym.sumIm;
            outDifRe       <= sym.difRe;
            outDifIm       <= sym.difIm;
            outInterpolate <= sym.interpolate;
        end
    end

endmodule

//--- hdl/stcAlignTop.sv
`timescale 1ns/1ps

module stcAlignTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           estimatesDone,
    input  logic           lastSample,
    input  stcPkg::tapNdxT ndx0,
    input  stcPkg::tapNdxT ndx1,
    output logic           trellisStart,
    // sample input, four-phase
    input  logic           inReq,
    output logic           inAck,
    input  logic           inSof,
    input  stcPkg::sampleT inRe,
    input  stcPkg::sampleT inIm,
    // symbol output, four-phase
    output logic           outReq,
    input  logic           outAck,
    output stcPkg::symbolT outSumRe,
    output stcPkg::symbolT outSumIm,
    output stcPkg::symbolT outDifRe,
    output stcPkg::symbolT outDifIm,
    output logic           outInterpolate
);

    sampleIf  smpBus ();
    tapPairIf tapBus ();
    symbolIf  symBus ();

    stcSampleCapture u_capture (
        .clk   (clk),
        .reset (reset),
        .inReq (inReq),
        .inSof (inSof),
        .inRe  (inRe),
        .inIm  (inIm),
        .inAck (inAck),
        .smp   (smpBus)
    );

    stcFrameAlign u_align (
        .clk           (clk),
        .reset         (reset),
        .estimatesDone (estimatesDone),
        .lastSample    (lastSample),
        .ndx0          (ndx0),
        .ndx1          (ndx1),
        .trellisStart  (trellisStart),
        .smp           (smpBus),
        .taps          (tapBus)
    );

    stcBranchCombiner u_combiner (
        .clk   (clk),
        .reset (reset),
        .taps  (tapBus),
        .sym   (symBus)
    );

    stcOutputPort u_outPort (
        .clk            (clk),
        .reset          (reset),
        .sym            (symBus),
        .outReq         (outReq),
        .outAck         (outAck),
        .outSumRe       (outSumRe),
        .outSumIm       (outSumIm),
        .outDifRe       (outDifRe),
        .outDifIm       (outDifIm),
        .outInterpolate (outInterpolate)
    );

endmodule

//--- verification/stcAlign_properties.sv
`timescale 1ns/1ps

module stcAlignProperties (
    input logic           clk,
    input logic           reset,
    input logic           inReq,
    input logic           inAck,
    input logic           outReq,
    input logic           outAck,
    input stcPkg::symbolT outSumRe,
    input stcPkg::symbolT outSumIm,
    input stcPkg::symbolT outDifRe,
    input stcPkg::symbolT outDifIm,
    input logic           outInterpolate,
    input logic           wrEn,
    input logic           full
);

    int assertFails = 0;   // failed assertions so far

    // input side four-phase order
    ackRise: assert property (@(posedge clk) disable iff (reset) $rose(inAck) |-> $past(inReq))
        else begin
            $error("inAck rose without a request");
            assertFails++;
        end
    ackFall: assert property (@(posedge clk) disable iff (reset) $fell(inAck) |-> !$past(inReq))
        else begin
            $error("inAck fell while the request was still high");
            assertFails++;
        end

    // output side four-phase order
    reqHold: assert property (@(posedge clk) disable iff (reset) outReq && !outAck |=> outReq)
        else begin
            $error("outReq dropped before outAck");
            assertFails++;
        end
    reqRise: assert property (@(posedge clk) disable iff (reset) $rose(outReq) |-> !outAck)
        else begin
            $error("outReq rose while outAck was still high");
            assertFails++;
        end
    dataStable: assert property (@(posedge clk) disable iff (reset)
        outReq && $past(outReq) |->
        $stable({outSumRe, outSumIm, outDifRe, outDifIm, outInterpolate}))
        else begin
            $error("output data changed while outReq was high");
            assertFails++;
        end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (reset) !(wrEn && full))
        else begin
            $error("buffer write while full");
            assertFails++;
        end

endmodule

bind stcAlignTop stcAlignProperties u_props (
    .clk            (clk),
    .reset          (reset),
    .inReq          (inReq),
    .inAck          (inAck),
    .outReq         (outReq),
    .outAck         (outAck),
    .outSumRe       (outSumRe),
    .outSumIm       (outSumIm),
    .outDifRe       (outDifRe),
    .outDifIm       (outDifIm),
    .outInterpolate (outInterpolate),
    .wrEn           (smpBus.wrEn),
    .full           (smpBus.full)
);

//--- verification/stcAlignChecker.sv
`timescale 1ns/1ps

module stcAlignChecker (
    input  logic           clk,
    input  logic           reset,
    input  logic           outReq,
    input  stcPkg::symbolT outSumRe,
    input  stcPkg::symbolT outSumIm,
    input  stcPkg::symbolT outDifRe,
    input  stcPkg::symbolT outDifIm,
    input  logic           outInterpolate,
    input  logic           trellisStart,
    input  logic           estGiven,
    input  logic           sofGiven,
    output int             rcvCount,
    output int             errTotal
);

    int   testId = 0;
    int   ndxA, ndxB, sofIdx, reBase, reStep, imBase, imStep, expCount;
    int   firstExp [4];
    int   testErrs = 0;
    int   passCnt = 0;
    int   failCnt = 0;
    logic reqPrev = 1'b0;

    initial begin
        rcvCount = 0;
        errTotal = 0;
    end

    function automatic int clampSym(input int v);
        if (v > stcPkg::SYM_MAX) return stcPkg::SYM_MAX;
        if (v < stcPkg::SYM_MIN) return stcPkg::SYM_MIN;
        return v;
    endfunction

    // ramp value of sample k wrapped to the sample width
    function automatic int rampAt(input int base, input int step, input int k);
        stcPkg::sampleT s;
        s = stcPkg::sampleT'(base + k * step);
        return int'(s);
    endfunction

    task automatic startTest(input int id, input int n0, input int n1, input int sof,
                             input int rb, input int rs, input int ib, input int is,
                             input int cnt, input int e0, input int e1, input int e2,
                             input int e3);
        testId = id;
        ndxA = n0;
        ndxB = n1;
        sofIdx = sof;
        reBase = rb;
        reStep = rs;
        imBase = ib;
        imStep = is;
        expCount = cnt;
        firstExp = '{e0, e1, e2, e3};
        testErrs = 0;
        rcvCount = 0;
    endtask

    task automatic fail(input string msg);
        $display("%s", msg);
        testErrs++;
        errTotal++;
    endtask

    task automatic checkSymbol();
        int    p;
        int    q;
        int    got [5];
        int    exp [5];
        string msg;
        p = sofIdx + stcPkg::PILOT_LEN + rcvCount + ndxA;
        q = sofIdx + stcPkg::PILOT_LEN + rcvCount + ndxB;
        got = '{outSumRe, outSumIm, outDifRe, outDifIm, outInterpolate};
        exp[0] = clampSym(rampAt(reBase, reStep, p) + rampAt(reBase, reStep, q));
        exp[1] = clampSym(rampAt(imBase, imStep, p) + rampAt(imBase, imStep, q));
        exp[2] = clampSym(rampAt(reBase, reStep, p) - rampAt(reBase, reStep, q));
        exp[3] = clampSym(rampAt(imBase, imStep, p) - rampAt(imBase, imStep, q));
        exp[4] = (rcvCount % 4 == 3);   // every fourth symbol of the frame
        if (rcvCount >= expCount) begin
            fail($sformatf("Test %0d received more symbols than expected", testId));
        end else if (got != exp) begin
            msg = $sformatf("Mismatch at %0d ns: test %0d symbol %0d got %0d %0d %0d %0d %0d",
                            $time, testId, rcvCount, got[0], got[1], got[2], got[3], got[4]);
            fail({msg, $sformatf(" exp %0d %0d %0d %0d %0d",
                                 exp[0], exp[1], exp[2], exp[3], exp[4])});
        end else if (rcvCount == 0 && (got[0] != firstExp[0] || got[1] != firstExp[1] ||
                                       got[2] != firstExp[2] || got[3] != firstExp[3])) begin
            fail($sformatf("Mismatch at %0d ns: test %0d first symbol differs from trace",
                $time, testId));
        end
        rcvCount++;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if ((trellisStart || outReq) && !(estGiven && sofGiven))
                fail($sformatf("Test %0d gave output before estimatesDone and sof",
                               testId));
            if (outReq && !reqPrev) checkSymbol();   // data is stable from the rising request
        end
        reqPrev = outReq;
    end

    task automatic endTest();
        if (rcvCount != expCount)
            fail($sformatf("Test %0d got %0d symbols instead of %0d", testId, rcvCount, expCount));
        if (testErrs == 0) passCnt++;
        else failCnt++;
        $display("Test %0d %s: %0d symbols, %0d errors", testId,
                 (testErrs == 0) ? "passed" : "failed", rcvCount, testErrs);
    endtask

    task automatic printCounts();
        $display("Tests passed %0d, failed %0d, errors %0d", passCnt, failCnt, errTotal);
    endtask

endmodule

//--- verification/stcAlignTb.sv
`timescale 1ns/1ps

module stcAlignTb;

    logic           clk = 1'b0;
    logic           reset = 1'b1;
    logic           estimatesDone = 1'b0;
    logic           lastSample = 1'b0;
    stcPkg::tapNdxT ndx0 = '0;
    stcPkg::tapNdxT ndx1 = '0;
    logic           inReq = 1'b0;
    logic           inSof = 1'b0;
    stcPkg::sampleT inRe = '0;
    stcPkg::sampleT inIm = '0;
    logic           outAck = 1'b0;
    logic           estGiven = 1'b0;   // estimatesDone already given in this test
    logic           sofGiven = 1'b0;   // sof sample accepted in this test
    logic           trellisStart, inAck, outReq, outInterpolate;
    stcPkg::symbolT outSumRe, outSumIm, outDifRe, outDifIm;
    int             rcvCount, errTotal;
    int             maxDelay = 0;
    int             ackCnt = 0;
    int             ackDelay = 0;
    bit             hung = 1'b0;

    always #5 clk = ~clk;

    stcAlignTop u_dut (.*);

    stcAlignChecker u_checker (.*);

    // slow acknowledger with a random delay per symbol
    always @(posedge clk) begin
        if (outReq && !outAck) begin
            if (ackCnt >= ackDelay) begin
                outAck <= #1 1'b1;
                ackCnt = 0;
                ackDelay = $urandom % (maxDelay + 1);
            end else begin
                ackCnt++;
            end
        end else if (!outReq && outAck) begin
            outAck <= #1 1'b0;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sendSample(input int k, input int sof, input int rb, input int rs,
                              input int ib, input int is);
        int n;
        inReq = 1'b1;
        inSof = (k == sof);
        inRe = stcPkg::sampleT'(rb + k * rs);
        inIm = stcPkg::sampleT'(ib + k * is);
        for (n = 0; !inAck && n < 1000; n++) nextCycle();
        if (!inAck) begin
            $display("Timed out waiting for inAck on sample %0d", k);
            hung = 1'b1;
        end else if (k == sof) begin
            sofGiven = 1'b1;
        end
        inReq = 1'b0;
        for (n = 0; inAck && n < 1000; n++) nextCycle();
        if (inAck) begin
            $display("Timed out waiting for inAck to fall on sample %0d", k);
            hung = 1'b1;
        end
    endtask

    task automatic pulseEstimates();
        estimatesDone = 1'b1;
        estGiven = 1'b1;
        nextCycle();
        estimatesDone = 1'b0;
    endtask

    // trace fields ndx0 ndx1 sof nSamples estAfter maxDelay reBase reStep imBase imStep nSym first[4]
    task automatic runTest(input int id, input int f [15]);
        int k;
        int n;
        ndx0 = stcPkg::tapNdxT'(f[0]);
        ndx1 = stcPkg::tapNdxT'(f[1]);
        maxDelay = f[5];
        estGiven = 1'b0;
        sofGiven = 1'b0;
        u_checker.startTest(id, f[0], f[1], f[2], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14]);
        for (k = 0; k < f[3] && !hung; k++) begin
            if (k == f[4]) pulseEstimates();
            sendSample(k, f[2], f[6], f[7], f[8], f[9]);
        end
        if (f[4] >= f[3]) pulseEstimates();
        for (n = 0; rcvCount < f[10] && n < 20000; n++) nextCycle();
        if (rcvCount < f[10]) begin
            $display("Timed out waiting for symbols in test %0d", id);
            hung = 1'b1;
        end
        for (n = 0; (outReq || outAck) && n < 1000; n++) nextCycle();
        if (outReq || outAck) begin
            $display("Timed out waiting for the output handshake to finish in test %0d", id);
            hung = 1'b1;
        end
        lastSample = 1'b1;   // close the frame
        nextCycle();
        lastSample = 1'b0;
        repeat (40) nextCycle();   // room for any stray symbol to show up
        u_checker.endTest();
    endtask

    initial begin
        int    fd;
        int    id;
        int    f [15];
        string line;
        void'($urandom(57));
        id = 0;
        fd = $fopen("verification/stcAlignTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            hung = 1'b1;
        end
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        while (fd != 0 && !$feof(fd) && !hung) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14]) == 15) begin
                    id++;
                    runTest(id, f);
                end
            end
        end
        u_checker.printCounts();
        if (!hung && errTotal == 0 && u_dut.u_props.assertFails == 0 && id > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/stcPkg.sv
hdl/stcInterfaces.sv
hdl/stcSampleCapture.sv
hdl/stcTwoReadRam.sv
hdl/stcFrameAlign.sv
hdl/stcBranchCombiner.sv
hdl/stcOutputPort.sv
hdl/stcAlignTop.sv
verification/stcAlign_properties.sv
verification/stcAlignChecker.sv
verification/stcAlignTb.sv

//--- verification/stcAlignTrace.txt
# ndx0 ndx1 sofIdx nSamples estAfter maxAckDelay reBase reStep imBase imStep
# nSym sumRe0 sumIm0 difRe0 difIm0  (samples are ramps, value = base + k * step)
0 1 4 60 0 0 10 3 -100 2 17 239 -54 -3 -2
-5 6 2 50 0 1 -300 5 200 -4 9 -255 124 -55 44
-8 7 1 48 45 2 0 1 50 0 8 65 100 -15 0
0 2 0 44 10 0 2000 0 -2000 0 5 2047 -2048 0 0
3 -2 6 70 3 7 1 7 900 -9 25 541 1107 35 -45
